// File: common/dataPathPkg.sv
package dataPathPkg;

	// default sizes, the top level passes these down as module parameters
	localparam int dataWidth = 32; // one word
	localparam int numRegs = 16;

	// ALU operation codes
	localparam int opWidth = 5;

	localparam logic [opWidth-1:0] opAdd = 5'b00011;
	localparam logic [opWidth-1:0] opSub = 5'b00100;
	localparam logic [opWidth-1:0] opShr = 5'b00101; // logical
	localparam logic [opWidth-1:0] opShl = 5'b00110;
	localparam logic [opWidth-1:0] opRor = 5'b00111;
	localparam logic [opWidth-1:0] opRol = 5'b01000;
	localparam logic [opWidth-1:0] opAnd = 5'b01001;
	localparam logic [opWidth-1:0] opMul = 5'b01010; // signed, full 64-bit product
	localparam logic [opWidth-1:0] opOr = 5'b01011;
	localparam logic [opWidth-1:0] opNeg = 5'b01100;
	localparam logic [opWidth-1:0] opNot = 5'b01101;

	// Bus source index.
	// Values 0 to numRegs-1 select a general register directly, the special
	// registers follow in the order below, and srcNone puts zero on the bus.
	localparam int srcWidth = 5;

	localparam logic [srcWidth-1:0] srcHi = 5'd16;
	localparam logic [srcWidth-1:0] srcLo = 5'd17;
	localparam logic [srcWidth-1:0] srcZHigh = 5'd18;
	localparam logic [srcWidth-1:0] srcZLow = 5'd19;
	localparam logic [srcWidth-1:0] srcPc = 5'd20;
	localparam logic [srcWidth-1:0] srcMdr = 5'd21;
	localparam logic [srcWidth-1:0] srcInPort = 5'd22;
	localparam logic [srcWidth-1:0] srcY = 5'd23;
	localparam logic [srcWidth-1:0] srcNone = 5'd24; // nothing drives, bus reads 0

endpackage

// File: src/busMux.sv
module busMux #(
	parameter int dataWidth = 32,
	parameter int numRegs = 16
) (
	input logic [numRegs-1:0] regOut,
	input logic hiOut,
	input logic loOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic pcOut,
	input logic mdrOut,
	input logic inPortOut,
	input logic yOut,
	input logic [numRegs-1:0][dataWidth-1:0] regData,
	input logic [dataWidth-1:0] hiData,
	input logic [dataWidth-1:0] loData,
	input logic [2*dataWidth-1:0] zData,
	input logic [dataWidth-1:0] pcData,
	input logic [dataWidth-1:0] mdrData,
	input logic [dataWidth-1:0] inPortValue,
	input logic [dataWidth-1:0] yData,
	output logic [dataWidth-1:0] busData
);

	localparam int idxWidth = $clog2(numRegs);

	logic [dataPathPkg::srcWidth-1:0] src; // winning source index

	// scan from the highest index down so the lowest strobe ends up in src
	always_comb begin
		src = dataPathPkg::srcNone;
		if (yOut) src = dataPathPkg::srcY;
		if (inPortOut) src = dataPathPkg::srcInPort;
		if (mdrOut) src = dataPathPkg::srcMdr;
		if (pcOut) src = dataPathPkg::srcPc;
		if (zLowOut) src = dataPathPkg::srcZLow;
		if (zHighOut) src = dataPathPkg::srcZHigh;
		if (loOut) src = dataPathPkg::srcLo;
		if (hiOut) src = dataPathPkg::srcHi;
		for (int i = numRegs - 1; i >= 0; i--) begin
			if (regOut[i]) src = dataPathPkg::srcWidth'(i);
		end
	end

	always_comb begin
		case (src)
			dataPathPkg::srcHi: busData = hiData;
			dataPathPkg::srcLo: busData = loData;
			dataPathPkg::srcZHigh: busData = zData[2*dataWidth-1:dataWidth];
			dataPathPkg::srcZLow: busData = zData[dataWidth-1:0];
			dataPathPkg::srcPc: busData = pcData;
			dataPathPkg::srcMdr: busData = mdrData;
			dataPathPkg::srcInPort: busData = inPortValue;
			dataPathPkg::srcY: busData = yData;
			dataPathPkg::srcNone: busData = '0;
			default: busData = regData[src[idxWidth-1:0]]; // general register
		endcase
	end

endmodule

// File: regFile/regFile.sv
module regFile #(
	parameter int dataWidth = 32,
	parameter int numRegs = 16
) (
	input logic clock,
	input logic rstN,
	input logic [numRegs-1:0] regIn,
	input logic [dataWidth-1:0] busData,
	output logic [numRegs-1:0][dataWidth-1:0] regData
);

	// Every register watches the bus and loads on its own strobe.
	// Several strobes may be high together and take the same word.
	always_ff @(posedge clock) begin
		if (!rstN) begin
			regData <= '0;
		end else begin
			for (int i = 0; i < numRegs; i++) begin
				if (regIn[i]) begin
					regData[i] <= busData;
				end
			end
		end
	end

endmodule

// File: alu/alu.sv
module alu #(
	parameter int dataWidth = 32
) (
	input logic [dataPathPkg::opWidth-1:0] op,
	input logic incPc,
	input logic [dataWidth-1:0] aIn, // from Y
	input logic [dataWidth-1:0] bIn, // from the bus
	output logic [2*dataWidth-1:0] result
);

	localparam int shWidth = $clog2(dataWidth);

	logic [shWidth-1:0] shAmt;
	logic [dataWidth-1:0] sum;
	logic [dataWidth-1:0] diff;
	logic [dataWidth-1:0] negB;
	logic [dataWidth-1:0] incVal;
	logic [2*dataWidth-1:0] rorWide;
	logic [2*dataWidth-1:0] rolWide;
	logic signed [2*dataWidth-1:0] prod;

	function automatic logic [2*dataWidth-1:0] signExt(input logic [dataWidth-1:0] v);
		return {{dataWidth{v[dataWidth-1]}}, v};
	endfunction

	function automatic logic [2*dataWidth-1:0] zeroExt(input logic [dataWidth-1:0] v);
		return {{dataWidth{1'b0}}, v};
	endfunction

	assign shAmt = bIn[shWidth-1:0]; // only the low bits count so larger amounts wrap
	assign sum = aIn + bIn;
	assign diff = aIn - bIn;
	assign negB = -bIn;
	assign incVal = bIn + dataWidth'(1); // wraps to 0 from all ones

	// rotates through a doubled copy of aIn
	assign rorWide = {aIn, aIn} >> shAmt;
	assign rolWide = {aIn, aIn} << shAmt;

	// both operands widened with sign
	assign prod = (2*dataWidth)'($signed(aIn)) * (2*dataWidth)'($signed(bIn));

	always_comb begin
		if (incPc) begin
			result = zeroExt(incVal); // PC step ignores op
		end else begin
			case (op)
				dataPathPkg::opAdd: result = signExt(sum);
				dataPathPkg::opSub: result = signExt(diff);
				dataPathPkg::opAnd: result = zeroExt(aIn & bIn);
				dataPathPkg::opOr: result = zeroExt(aIn | bIn);
				dataPathPkg::opShr: result = zeroExt(aIn >> shAmt);
				dataPathPkg::opShl: result = zeroExt(aIn << shAmt);
				dataPathPkg::opRor: result = zeroExt(rorWide[dataWidth-1:0]);
				dataPathPkg::opRol: result = zeroExt(rolWide[2*dataWidth-1:dataWidth]);
				dataPathPkg::opNeg: result = signExt(negB);
				dataPathPkg::opNot: result = zeroExt(~bIn);
				dataPathPkg::opMul: result = prod;
				default: result = '0;
			endcase
		end
	end

endmodule

// File: src/specialRegs.sv
module specialRegs #(
	parameter int dataWidth = 32
) (
	input logic clock,
	input logic rstN,
	input logic read, // MDR takes memory data instead of the bus
	input logic hiIn,
	input logic loIn,
	input logic zIn,
	input logic pcIn,
	input logic mdrIn,
	input logic yIn,
	input logic inPortIn,
	input logic [dataWidth-1:0] busData,
	input logic [dataWidth-1:0] mDataIn,
	input logic [dataWidth-1:0] inPortData,
	input logic [2*dataWidth-1:0] aluResult,
	output logic [dataWidth-1:0] hiData,
	output logic [dataWidth-1:0] loData,
	output logic [2*dataWidth-1:0] zData,
	output logic [dataWidth-1:0] pcData,
	output logic [dataWidth-1:0] mdrData,
	output logic [dataWidth-1:0] inPortValue,
	output logic [dataWidth-1:0] yData
);

	logic [dataWidth-1:0] mdrNext;

	assign mdrNext = read ? mDataIn : busData;

	always_ff @(posedge clock) begin
		if (!rstN) begin
			hiData <= '0;
			loData <= '0;
			zData <= '0;
			pcData <= '0;
			mdrData <= '0;
			inPortValue <= '0;
			yData <= '0;
		end else begin
			if (hiIn) hiData <= busData;
			if (loIn) loData <= busData;
			if (zIn) zData <= aluResult; // both halves in one go
			if (pcIn) pcData <= busData;
			if (mdrIn) mdrData <= mdrNext;
			if (yIn) yData <= busData; // operand A for the next ALU cycle

			// the input port samples the outside pins, never the bus
			if (inPortIn) inPortValue <= inPortData;
		end
	end

endmodule

// File: src/dataPath.sv
module dataPath #(
	parameter int dataWidth = dataPathPkg::dataWidth,
	parameter int numRegs = dataPathPkg::numRegs
) (
	input logic clock,
	input logic rstN,
	input logic read,
	input logic incPc,
	input logic [dataPathPkg::opWidth-1:0] op,
	input logic [dataWidth-1:0] mDataIn,
	input logic [dataWidth-1:0] inPortData,
	// source strobes
	input logic [numRegs-1:0] regOut,
	input logic hiOut,
	input logic loOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic pcOut,
	input logic mdrOut,
	input logic inPortOut,
	input logic yOut,
	// load strobes
	input logic [numRegs-1:0] regIn,
	input logic hiIn,
	input logic loIn,
	input logic zIn,
	input logic pcIn,
	input logic mdrIn,
	input logic yIn,
	input logic inPortIn,
	output logic [dataWidth-1:0] busOut
);

	logic [dataWidth-1:0] busData;
	logic [numRegs-1:0][dataWidth-1:0] regData;
	logic [dataWidth-1:0] hiData;
	logic [dataWidth-1:0] loData;
	logic [2*dataWidth-1:0] zData;
	logic [dataWidth-1:0] pcData;
	logic [dataWidth-1:0] mdrData;
	logic [dataWidth-1:0] inPortValue;
	logic [dataWidth-1:0] yData;
	logic [2*dataWidth-1:0] aluResult;

	assign busOut = busData; // lets the testbench watch every transfer

	regFile #(.dataWidth(dataWidth), .numRegs(numRegs)) u_regFile (
		.clock(clock), .rstN(rstN), .regIn(regIn), .busData(busData), .regData(regData)
	);

	specialRegs #(.dataWidth(dataWidth)) u_specialRegs (
		.clock(clock), .rstN(rstN), .read(read),
		.hiIn(hiIn), .loIn(loIn), .zIn(zIn), .pcIn(pcIn),
		.mdrIn(mdrIn), .yIn(yIn), .inPortIn(inPortIn),
		.busData(busData), .mDataIn(mDataIn), .inPortData(inPortData), .aluResult(aluResult),
		.hiData(hiData), .loData(loData), .zData(zData), .pcData(pcData),
		.mdrData(mdrData), .inPortValue(inPortValue), .yData(yData)
	);

	alu #(.dataWidth(dataWidth)) u_alu (
		.op(op), .incPc(incPc), .aIn(yData), .bIn(busData), .result(aluResult)
	);

	busMux #(.dataWidth(dataWidth), .numRegs(numRegs)) u_busMux (
		.regOut(regOut), .hiOut(hiOut), .loOut(loOut),
		.zHighOut(zHighOut), .zLowOut(zLowOut), .pcOut(pcOut),
		.mdrOut(mdrOut), .inPortOut(inPortOut), .yOut(yOut),
		.regData(regData), .hiData(hiData), .loData(loData), .zData(zData),
		.pcData(pcData), .mdrData(mdrData), .inPortValue(inPortValue), .yData(yData),
		.busData(busData)
	);

endmodule

// File: tb/dataPath_chk.sv
module dataPathChk #(
	parameter int dataWidth = 32,
	parameter int numRegs = 16
) (
	input logic clock,
	input logic rstN,
	input logic [numRegs-1:0] regOut,
	input logic hiOut,
	input logic loOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic pcOut,
	input logic mdrOut,
	input logic inPortOut,
	input logic yOut,
	input logic [dataWidth-1:0] busOut,
	input logic [numRegs-1:0][dataWidth-1:0] regData,
	input logic [dataWidth-1:0] hiData,
	input logic [dataWidth-1:0] loData,
	input logic [2*dataWidth-1:0] zData,
	input logic [dataWidth-1:0] pcData,
	input logic [dataWidth-1:0] mdrData,
	input logic [dataWidth-1:0] inPortValue,
	input logic [dataWidth-1:0] yData
);

	int failCount = 0; // read by the testbench at the end

	logic [numRegs+7:0] strobes;
	logic allClear;

	assign strobes = {regOut, hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, yOut};
	assign allClear = (regData == '0) && (hiData == '0) && (loData == '0) && (zData == '0)
		&& (pcData == '0) && (mdrData == '0) && (inPortValue == '0) && (yData == '0);

	oneSource: assert property (@(posedge clock) disable iff (!rstN) $onehot0(strobes))
		else begin
			$error("several source strobes drive the bus");
			failCount++;
		end

	idleBus: assert property (@(posedge clock) disable iff (!rstN)
		(strobes == '0) |-> (busOut == '0))
		else begin
			$error("bus not zero without a source");
			failCount++;
		end

	resetClears: assert property (@(posedge clock) !rstN |=> allClear)
		else begin
			$error("register not cleared by reset");
			failCount++;
		end

endmodule

bind dataPath dataPathChk #(.dataWidth(dataWidth), .numRegs(numRegs)) u_chk (
	.clock(clock), .rstN(rstN),
	.regOut(regOut), .hiOut(hiOut), .loOut(loOut), .zHighOut(zHighOut), .zLowOut(zLowOut),
	.pcOut(pcOut), .mdrOut(mdrOut), .inPortOut(inPortOut), .yOut(yOut), .busOut(busOut),
	.regData(regData), .hiData(hiData), .loData(loData), .zData(zData), .pcData(pcData),
	.mdrData(mdrData), .inPortValue(inPortValue), .yData(yData)
);

// File: tb/dataPathTb.sv
module dataPathTb;

	localparam int numRegs = dataPathPkg::numRegs;
	localparam logic [4:0] srcNone = dataPathPkg::srcNone;

	// load masks with bit 0 for HI up to bit 6 for the input port
	localparam logic [6:0] noLoad = 7'b0000000;
	localparam logic [6:0] toHi = 7'b0000001;
	localparam logic [6:0] toLo = 7'b0000010;
	localparam logic [6:0] toZ = 7'b0000100;
	localparam logic [6:0] toPc = 7'b0001000;
	localparam logic [6:0] toMdr = 7'b0010000;
	localparam logic [6:0] toY = 7'b0100000;
	localparam logic [6:0] toPort = 7'b1000000;

	logic clock;
	logic rstN;
	logic read;
	logic incPc;
	logic [dataPathPkg::opWidth-1:0] op;
	logic [31:0] mDataIn;
	logic [31:0] inPortData;
	logic [numRegs-1:0] regOut;
	logic hiOut;
	logic loOut;
	logic zHighOut;
	logic zLowOut;
	logic pcOut;
	logic mdrOut;
	logic inPortOut;
	logic yOut;
	logic [numRegs-1:0] regIn;
	logic hiIn;
	logic loIn;
	logic zIn;
	logic pcIn;
	logic mdrIn;
	logic yIn;
	logic inPortIn;
	logic [31:0] busOut;

	integer seed = 32'h48e3_d718;

	dataPath #(.dataWidth(dataPathPkg::dataWidth), .numRegs(numRegs)) u_dataPath (
		.clock(clock), .rstN(rstN), .read(read), .incPc(incPc), .op(op),
		.mDataIn(mDataIn), .inPortData(inPortData),
		.regOut(regOut), .hiOut(hiOut), .loOut(loOut), .zHighOut(zHighOut),
		.zLowOut(zLowOut), .pcOut(pcOut), .mdrOut(mdrOut), .inPortOut(inPortOut), .yOut(yOut),
		.regIn(regIn), .hiIn(hiIn), .loIn(loIn), .zIn(zIn), .pcIn(pcIn),
		.mdrIn(mdrIn), .yIn(yIn), .inPortIn(inPortIn), .busOut(busOut)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Regression failed");
		$fatal(1);
	endtask

	task automatic checkEq(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			failRun($sformatf("FAILED %s: expected %h, actual %h", name, expected, actual));
		end
	endtask

	// one bus cycle with a single source and any loads
	task automatic step(input logic [4:0] src, input logic [numRegs-1:0] regLoad,
			input logic [6:0] load);
		@(posedge clock);
		regOut <= '0;
		{hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, yOut} <= '0;
		read <= 1'b0;
		incPc <= 1'b0;
		case (src)
			dataPathPkg::srcHi: hiOut <= 1'b1;
			dataPathPkg::srcLo: loOut <= 1'b1;
			dataPathPkg::srcZHigh: zHighOut <= 1'b1;
			dataPathPkg::srcZLow: zLowOut <= 1'b1;
			dataPathPkg::srcPc: pcOut <= 1'b1;
			dataPathPkg::srcMdr: mdrOut <= 1'b1;
			dataPathPkg::srcInPort: inPortOut <= 1'b1;
			dataPathPkg::srcY: yOut <= 1'b1;
			dataPathPkg::srcNone: ; // idle bus
			default: regOut <= numRegs'(1) << src;
		endcase
		regIn <= regLoad;
		{inPortIn, yIn, mdrIn, pcIn, zIn, loIn, hiIn} <= load;
	endtask

	task automatic readBus(input logic [4:0] src, output logic [31:0] value);
		step(src, '0, noLoad);
		@(negedge clock); // bus has settled by mid cycle
		value = busOut;
	endtask

	task automatic loadReg(input logic [3:0] r, input logic [31:0] value);
		step(srcNone, '0, toMdr);
		read <= 1'b1;
		mDataIn <= value;
		step(dataPathPkg::srcMdr, numRegs'(1) << r, noLoad);
	endtask

	task automatic waitBusIdle();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (busOut !== 32'd0) begin
			if (cycles == 10) begin
				failRun("bus did not return to zero after reset");
			end else begin
				@(negedge clock);
				cycles++;
			end
		end
	endtask

	// ALU rules with the result sign or zero extended to 64 bits
	function automatic logic [63:0] expectAlu(input logic [4:0] code, input logic [31:0] a,
			input logic [31:0] b);
		logic [31:0] r;
		logic [4:0] s;
		logic signedRes;
		s = b[4:0];
		r = '0;
		signedRes = 1'b0;
		case (code)
			dataPathPkg::opAdd: begin
				r = a + b;
				signedRes = 1'b1;
			end
			dataPathPkg::opSub: begin
				r = a - b;
				signedRes = 1'b1;
			end
			dataPathPkg::opNeg: begin
				r = 32'd0 - b;
				signedRes = 1'b1;
			end
			dataPathPkg::opAnd: r = a & b;
			dataPathPkg::opOr: r = a | b;
			dataPathPkg::opShr: r = a >> s;
			dataPathPkg::opShl: r = a << s;
			dataPathPkg::opRor: r = (s == 5'd0) ? a : ((a >> s) | (a << (6'd32 - s)));
			dataPathPkg::opRol: r = (s == 5'd0) ? a : ((a << s) | (a >> (6'd32 - s)));
			dataPathPkg::opNot: r = ~b;
			default: r = '0;
		endcase
		return signedRes ? {{32{r[31]}}, r} : {32'd0, r};
	endfunction

	task automatic checkReset();
		logic [31:0] value;
		for (int s = 0; s <= 24; s++) begin
			readBus(5'(s), value);
			checkEq($sformatf("reset source %0d", s), 64'd0, {32'd0, value});
		end
	endtask

	task automatic checkMdrTransfer();
		logic [31:0] first;
		logic [31:0] second;
		logic [31:0] value;
		logic [3:0] r;
		first = $random(seed);
		second = $random(seed);
		r = 4'($random(seed));
		loadReg(r, first);
		readBus(5'(r), value);
		checkEq("mdr to register", {32'd0, first}, {32'd0, value});
		step(srcNone, '0, toMdr);
		read <= 1'b1;
		mDataIn <= second;
		step(5'(r), '0, toMdr); // read low so MDR takes the bus
		readBus(dataPathPkg::srcMdr, value);
		checkEq("mdr from bus", {32'd0, first}, {32'd0, value});
	endtask

	task automatic mulCase(input string name, input logic [31:0] a, input logic [31:0] b);
		logic [31:0] lo;
		logic [31:0] hi;
		logic [63:0] expected;
		loadReg(4'd4, a);
		step(5'd4, '0, toY);
		loadReg(4'd5, b);
		step(5'd5, '0, toZ);
		op <= dataPathPkg::opMul;
		step(dataPathPkg::srcZLow, '0, toLo);
		step(dataPathPkg::srcZHigh, '0, toHi);
		readBus(dataPathPkg::srcLo, lo);
		readBus(dataPathPkg::srcHi, hi);
		expected = {{32{a[31]}}, a} * {{32{b[31]}}, b};
		checkEq(name, expected, {hi, lo});
	endtask

	task automatic checkMultiply();
		mulCase("mul 12 by -5", 32'd12, 32'hffff_fffb);
		repeat (4) mulCase("mul random", $random(seed), $random(seed));
	endtask

	task automatic aluCase(input logic [4:0] code, input logic [31:0] a, input logic [31:0] b);
		logic [31:0] lo;
		logic [31:0] hi;
		loadReg(4'd1, a);
		step(5'd1, '0, toY);
		loadReg(4'd2, b);
		step(5'd2, '0, toZ);
		op <= code;
		readBus(dataPathPkg::srcZLow, lo);
		readBus(dataPathPkg::srcZHigh, hi);
		checkEq($sformatf("alu op %b a %h b %h", code, a, b), expectAlu(code, a, b), {hi, lo});
	endtask

	task automatic checkAluOps();
		logic [4:0] codes [10];
		codes = '{dataPathPkg::opAdd, dataPathPkg::opSub, dataPathPkg::opAnd, dataPathPkg::opOr,
			dataPathPkg::opShr, dataPathPkg::opShl, dataPathPkg::opRor, dataPathPkg::opRol,
			dataPathPkg::opNeg, dataPathPkg::opNot};
		for (int i = 0; i < 10; i++) begin
			aluCase(codes[i], 32'd12, 32'hffff_fffb); // 12 and -5
			repeat (3) aluCase(codes[i], $random(seed), $random(seed));
		end
	endtask

	task automatic pcCase(input logic [31:0] value);
		logic [31:0] expected;
		logic [31:0] got;
		expected = value + 32'd1; // wraps from all ones
		step(srcNone, '0, toMdr);
		read <= 1'b1;
		mDataIn <= value;
		step(dataPathPkg::srcMdr, '0, toPc);
		step(dataPathPkg::srcPc, '0, toZ);
		incPc <= 1'b1;
		step(dataPathPkg::srcZLow, '0, toPc);
		readBus(dataPathPkg::srcPc, got);
		checkEq($sformatf("pc increment from %h", value), {32'd0, expected}, {32'd0, got});
	endtask

	task automatic checkPcIncrement();
		pcCase($random(seed));
		pcCase(32'hffff_ffff);
		pcCase(32'd0);
	endtask

	task automatic checkInPort();
		logic [31:0] value;
		logic [31:0] got;
		value = $random(seed);
		step(srcNone, '0, toPort);
		inPortData <= value;
		readBus(dataPathPkg::srcInPort, got);
		checkEq("input port capture", {32'd0, value}, {32'd0, got});
		step(dataPathPkg::srcInPort, '0, toY);
		readBus(dataPathPkg::srcY, got);
		checkEq("input port to Y", {32'd0, value}, {32'd0, got});
	endtask

	initial begin
		rstN <= 1'b0;
		read <= 1'b0;
		incPc <= 1'b0;
		op <= dataPathPkg::opAdd;
		mDataIn <= '0;
		inPortData <= '0;
		regOut <= '0;
		{hiOut, loOut, zHighOut, zLowOut, pcOut, mdrOut, inPortOut, yOut} <= '0;
		regIn <= '0;
		{hiIn, loIn, zIn, pcIn, mdrIn, yIn, inPortIn} <= '0;
		repeat (4) @(posedge clock);
		rstN <= 1'b1;
		waitBusIdle();
		checkReset();
		checkMdrTransfer();
		checkMultiply();
		checkAluOps();
		checkPcIncrement();
		checkInPort();
		step(srcNone, '0, noLoad);
		@(negedge clock); // let the checker see the last cycle
		if (u_dataPath.u_chk.failCount == 0) begin
			$display("Regression passed");
			$finish;
		end else begin
			failRun("the bound checker flagged an assertion");
		end
	end

endmodule

// File: compile.f
common/dataPathPkg.sv
src/busMux.sv
regFile/regFile.sv
alu/alu.sv
src/specialRegs.sv
src/dataPath.sv
tb/dataPath_chk.sv
tb/dataPathTb.sv

// File: run.sh
#!/usr/bin/env bash
# build with Verilator, run, then decide the result from the simulation log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log build.log
verilator --binary --assert --top-module dataPathTb -f compile.f -o simv > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/simv +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
! grep -q "Regression failed" sim.log && grep -q "Regression passed" sim.log \
	&& echo "simulation passed" && exit 0
echo "simulation failed" && exit 1
